// File: verif/exec_patterns.txt
# st(0 alu,1 br) opcode funct3 alt imm pc | rs1 rdy val tag | rs2 rdy val tag | rob | value take target
# last column: 0 issue, 1 drain first, 2 flushed later, 3 flushed and flush after it (all hex)
0 33 0 0 00000000 00000000 1 00000005 0 1 00000007 0 0 0000000c 0 00000000 0
0 33 0 1 00000000 00000000 1 00000003 0 1 00000005 0 1 fffffffe 0 00000000 0
0 33 2 0 00000000 00000000 1 ffffffff 0 1 00000001 0 2 00000001 0 00000000 0
0 33 3 0 00000000 00000000 1 ffffffff 0 1 00000001 0 3 00000000 0 00000000 0
0 13 4 0 0ff00ff0 00000000 1 f0f0f0f0 0 0 00000000 0 4 ff00ff00 0 00000000 0
0 13 6 0 00005678 00000000 1 12340000 0 0 00000000 0 5 12345678 0 00000000 0
0 33 7 0 00000000 00000000 1 ff00ff00 0 1 0f0f0f0f 0 6 0f000f00 0 00000000 0
0 13 1 0 0000001f 00000000 1 00000001 0 0 00000000 0 7 80000000 0 00000000 0
0 33 5 0 00000000 00000000 1 80000000 0 1 00000004 0 0 08000000 0 00000000 0
0 33 5 1 00000000 00000000 1 80000000 0 1 00000024 0 1 f8000000 0 00000000 0
0 13 0 1 fffffc00 00000000 1 00000010 0 0 00000000 0 2 fffffc10 0 00000000 0
1 63 0 0 00000040 00001000 1 00000005 0 1 00000005 0 3 00000000 1 00001040 0
1 63 1 0 00000040 00001000 1 00000005 0 1 00000005 0 4 00000000 0 00001004 0
1 63 4 0 fffffff0 00002000 1 ffffffff 0 1 00000001 0 5 00000000 1 00001ff0 0
1 63 5 0 fffffff0 00002000 1 ffffffff 0 1 00000001 0 6 00000000 0 00002004 0
1 63 6 0 00000100 00003000 1 ffffffff 0 1 00000001 0 7 00000000 0 00003004 0
1 63 7 0 00000100 00003000 1 ffffffff 0 1 00000001 0 0 00000000 1 00003100 0
1 6f 0 0 00000800 00004000 0 deadbeef 6 0 deadbeef 6 1 00004004 1 00004800 0
1 67 0 0 00000010 00005000 1 00006001 0 0 deadbeef 5 2 00005004 1 00006010 0
0 13 0 0 00000003 00000000 0 deadbeef 5 0 00000000 0 4 00000126 0 00000000 1
1 63 0 0 00000020 00007000 0 deadbeef 4 1 00000126 0 6 00000000 1 00007020 0
0 13 0 0 00000023 00000000 1 00000100 0 0 00000000 0 5 00000123 0 00000000 0
0 13 0 0 00000001 00000000 0 deadbeef 7 0 00000000 0 0 00001001 0 00000000 1
0 13 4 0 00000fff 00000000 0 deadbeef 7 0 00000000 0 1 00001fff 0 00000000 0
0 33 0 0 00000000 00000000 0 deadbeef 7 1 00001000 0 2 00002000 0 00000000 0
0 13 1 0 00000004 00000000 0 deadbeef 7 0 00000000 0 3 00010000 0 00000000 0
1 63 0 0 00000040 00008000 0 deadbeef 7 1 00001000 0 4 00000000 1 00008040 0
1 63 1 0 00000040 00008000 0 deadbeef 7 1 00001000 0 5 00000000 0 00008004 0
1 63 6 0 00000040 00008000 0 deadbeef 7 1 00002000 0 6 00000000 1 00008040 0
1 6f 0 0 00000100 00000ffc 0 deadbeef 0 0 deadbeef 0 7 00001000 1 000010fc 0
0 33 0 0 00000000 00000000 0 deadbeef 7 1 00000001 0 0 00000000 0 00000000 2
1 63 0 0 00000040 00008000 0 deadbeef 7 1 00000001 0 1 00000000 0 00000000 2
1 67 0 0 00000010 00005000 0 deadbeef 7 0 deadbeef 7 2 00000000 0 00000000 3
0 13 0 0 00000001 00000000 1 00000007 0 0 00000000 0 7 00000008 0 00000000 0
1 63 1 0 00000008 00009000 1 00000001 0 1 00000002 0 0 00000000 1 00009008 0

// File: project.f
logic/rv32i_pkg.sv
logic/branch_cmp.sv
logic/branch_rs.sv
logic/alu_rs.sv
logic/cdb_arbiter.sv
logic/exec_core.sv
verif/exec_core_tb.sv

// File: verif/exec_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exec_core_tb;

  localparam int tags = 2 ** rv32i_pkg::rob_width;
  localparam int timeout_cycles = 400;
  // entries per station at the default depth
  localparam int rs_slots = 4;

  logic              clk;
  logic              rst;
  logic              flush;
  logic              br_issue;
  logic              alu_issue;
  logic              br_full;
  logic              alu_full;
  rv32i_pkg::issue_t br_issue_pkt;
  rv32i_pkg::issue_t alu_issue_pkt;
  rv32i_pkg::cdb_t   cdb;

  // scoreboard state indexed by rob tag
  logic [tags-1:0] pending;
  logic [tags-1:0] doomed;
  logic [tags-1:0] at_br;
  logic [31:0]     exp_value [tags];
  logic            exp_take [tags];
  logic [31:0]     exp_target [tags];
  logic [rv32i_pkg::rob_width-1:0] beat_tag;
  int              errors;
  int              timeouts;
  int              beats;
  logic            br_full_seen;
  logic            alu_full_seen;

  exec_core dut_i (
    .clk           (clk),
    .rst           (rst),
    .flush         (flush),
    .br_issue      (br_issue),
    .br_issue_pkt  (br_issue_pkt),
    .br_full       (br_full),
    .alu_issue     (alu_issue),
    .alu_issue_pkt (alu_issue_pkt),
    .alu_full      (alu_full),
    .cdb           (cdb)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // number of tags set in a mask
  function automatic int count_tags(input logic [tags-1:0] mask);
    int c;
    c = 0;
    for (int i = 0; i < tags; i++) begin
      if (mask[i]) begin
        c++;
      end
    end
    return c;
  endfunction

  task automatic wait_room(input logic to_br);
    int n;
    n = 0;
    @(negedge clk);
    while ((to_br ? br_full : alu_full) && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (n >= timeout_cycles) begin
      $display("timeout at %0t: station stayed full, issue not possible", $time);
      timeouts++;
    end
  endtask

  // a rob tag is reused only after its earlier beat was seen
  task automatic wait_tag(input logic [rv32i_pkg::rob_width-1:0] t);
    int n;
    n = 0;
    while (pending[t] && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (n >= timeout_cycles) begin
      $display("timeout at %0t: rob tag %0d never came back on the bus", $time, t);
      timeouts++;
    end
  endtask

  task automatic drain();
    int n;
    n = 0;
    while ((pending & ~doomed) != '0 && n < timeout_cycles) begin
      @(negedge clk);
      n++;
    end
    if (n >= timeout_cycles) begin
      $display("timeout at %0t: tags %b still in flight", $time, pending & ~doomed);
      timeouts++;
    end
  endtask

  // bus monitor sampled mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      // a station may only be full once all of its slots are taken
      assert (!br_full || count_tags(pending & at_br) >= rs_slots) else begin
        $display("CHECK FAILED %0t br_full got %b expected 0", $time, br_full);
        errors++;
      end
      assert (!alu_full || count_tags(pending & ~at_br) >= rs_slots) else begin
        $display("CHECK FAILED %0t alu_full got %b expected 0", $time, alu_full);
        errors++;
      end
      if (br_full) begin
        br_full_seen = 1'b1;
      end
      if (alu_full) begin
        alu_full_seen = 1'b1;
      end
      if (cdb.valid) begin
        beat_tag = cdb.rob;
        beats++;
        assert (pending[beat_tag] && !doomed[beat_tag]) else begin
          $display("unexpected bus beat at %0t for rob tag %0d, not in flight or flushed",
                   $time, beat_tag);
          errors++;
        end
        if (pending[beat_tag] && !doomed[beat_tag]) begin
          assert (cdb.value == exp_value[beat_tag]) else begin
            $display("CHECK FAILED %0t cdb.value (rob %0d) got %h expected %h",
                     $time, beat_tag, cdb.value, exp_value[beat_tag]);
            errors++;
          end
          assert (cdb.take == exp_take[beat_tag]) else begin
            $display("CHECK FAILED %0t cdb.take (rob %0d) got %b expected %b",
                     $time, beat_tag, cdb.take, exp_take[beat_tag]);
            errors++;
          end
          assert (cdb.target == exp_target[beat_tag]) else begin
            $display("CHECK FAILED %0t cdb.target (rob %0d) got %h expected %h",
                     $time, beat_tag, cdb.target, exp_target[beat_tag]);
            errors++;
          end
          pending[beat_tag] = 1'b0;
        end
      end
    end
  end

  initial begin
    int fd;
    int n;
    int seed;
    string line;
    rv32i_pkg::issue_t pkt;
    logic [3:0]  st;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic        alt;
    logic [31:0] imm;
    logic [31:0] pc;
    logic        r1;
    logic [31:0] v1;
    logic [2:0]  t1;
    logic        r2;
    logic [31:0] v2;
    logic [2:0]  t2;
    logic [2:0]  rob;
    logic [31:0] ev;
    logic        et;
    logic [31:0] etg;
    logic [3:0]  mark;
    rst = 1'b1;
    flush = 1'b0;
    br_issue = 1'b0;
    alu_issue = 1'b0;
    br_issue_pkt = '0;
    alu_issue_pkt = '0;
    pending = '0;
    doomed = '0;
    at_br = '0;
    errors = 0;
    timeouts = 0;
    beats = 0;
    br_full_seen = 1'b0;
    alu_full_seen = 1'b0;
    seed = $urandom(32'h635c);
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (!br_full && !alu_full) else begin
      $display("CHECK FAILED %0t br_full/alu_full got %b%b expected 00",
               $time, br_full, alu_full);
      errors++;
    end
    assert (!cdb.valid) else begin
      $display("CHECK FAILED %0t cdb.valid got %b expected 0", $time, cdb.valid);
      errors++;
    end
    fd = $fopen("verif/exec_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file verif/exec_patterns.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      st, opc, f3, alt, imm, pc, r1, v1, t1, r2, v2, t2,
                      rob, ev, et, etg, mark);
          if (n == 17) begin
            // marker 1 waits for a quiet bus and 2 or 3 mark flushed rows
            if (mark != 0) begin
              drain();
            end
            wait_tag(rob);
            wait_room(st == 4'd1);
            repeat ($urandom % 4) @(posedge clk);
            @(posedge clk);
            pkt = '0;
            pkt.opcode = opc;
            pkt.funct3 = f3;
            pkt.alt = alt;
            pkt.imm = imm;
            pkt.pc = pc;
            pkt.rs1.ready = r1;
            pkt.rs1.value = v1;
            pkt.rs1.tag = t1;
            pkt.rs2.ready = r2;
            pkt.rs2.value = v2;
            pkt.rs2.tag = t2;
            pkt.rob = rob;
            exp_value[rob] = ev;
            exp_take[rob] = et;
            exp_target[rob] = etg;
            pending[rob] = 1'b1;
            doomed[rob] = (mark >= 4'd2);
            at_br[rob] = (st == 4'd1);
            if (st == 4'd1) begin
              br_issue_pkt <= pkt;
              br_issue <= 1'b1;
            end else begin
              alu_issue_pkt <= pkt;
              alu_issue <= 1'b1;
            end
            @(posedge clk);
            br_issue <= 1'b0;
            alu_issue <= 1'b0;
            if (mark == 4'd3) begin
              drain();
              @(posedge clk);
              flush <= 1'b1;
              @(posedge clk);
              flush <= 1'b0;
              pending = pending & ~doomed;
              doomed = '0;
            end
          end else if (n > 0) begin
            $display("malformed pattern line: %s", line);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
    drain();
    assert (pending == '0) else begin
      $display("tags %b were issued but never appeared on the bus", pending);
      errors++;
    end
    assert (br_full_seen && alu_full_seen) else begin
      $display("a station never reported full during the burst (br %b, alu %b)",
               br_full_seen, alu_full_seen);
      errors++;
    end
    $display("run done: %0d check errors, %0d timeouts, %0d bus beats", errors, timeouts, beats);
    if (errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/exec_core.sv
`timescale 1ns/100ps
`default_nettype none

module exec_core #(
  parameter int BR_RS_DEPTH  = 2,
  parameter int ALU_RS_DEPTH = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              flush,
  input  logic              br_issue,
  input  rv32i_pkg::issue_t br_issue_pkt,
  output logic              br_full,
  input  logic              alu_issue,
  input  rv32i_pkg::issue_t alu_issue_pkt,
  output logic              alu_full,
  output rv32i_pkg::cdb_t   cdb
);

  logic            br_req;
  logic            br_grant;
  rv32i_pkg::cdb_t br_result;
  logic            alu_req;
  logic            alu_grant;
  rv32i_pkg::cdb_t alu_result;

  branch_rs #(
    .DEPTH (BR_RS_DEPTH)
  ) br_rs_i (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .issue     (br_issue),
    .issue_pkt (br_issue_pkt),
    .full      (br_full),
    .cdb       (cdb),
    .req       (br_req),
    .result    (br_result),
    .grant     (br_grant)
  );

  alu_rs #(
    .DEPTH (ALU_RS_DEPTH)
  ) alu_rs_i (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .issue     (alu_issue),
    .issue_pkt (alu_issue_pkt),
    .full      (alu_full),
    .cdb       (cdb),
    .req       (alu_req),
    .result    (alu_result),
    .grant     (alu_grant)
  );

  // single bus fed back to both stations
  cdb_arbiter arb_i (
    .clk        (clk),
    .rst        (rst),
    .flush      (flush),
    .br_req     (br_req),
    .alu_req    (alu_req),
    .br_result  (br_result),
    .alu_result (alu_result),
    .br_grant   (br_grant),
    .alu_grant  (alu_grant),
    .cdb        (cdb)
  );

endmodule

`default_nettype wire

// File: logic/cdb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module cdb_arbiter (
  input  logic            clk,
  input  logic            rst,
  input  logic            flush,
  input  logic            br_req,
  input  logic            alu_req,
  input  rv32i_pkg::cdb_t br_result,
  input  rv32i_pkg::cdb_t alu_result,
  output logic            br_grant,
  output logic            alu_grant,
  output rv32i_pkg::cdb_t cdb
);

  // set when the integer station won last
  logic            last_alu;
  logic            beat_valid;
  rv32i_pkg::cdb_t beat;

  assign br_grant  = br_req && (!alu_req || last_alu);
  assign alu_grant = alu_req && !br_grant;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      last_alu   <= 1'b0;
      beat_valid <= 1'b0;
    end else begin
      beat_valid <= br_grant || alu_grant;
      if (br_grant) begin
        last_alu <= 1'b0;
      end else if (alu_grant) begin
        last_alu <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    beat <= alu_grant ? alu_result : br_result;
  end

  always_comb begin
    cdb       = beat;
    cdb.valid = beat_valid;
  end

endmodule

`default_nettype wire

// File: logic/alu_rs.sv
`timescale 1ns/100ps
`default_nettype none

module alu_rs #(
  parameter int DEPTH = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              flush,
  input  logic              issue,
  input  rv32i_pkg::issue_t issue_pkt,
  output logic              full,
  input  rv32i_pkg::cdb_t   cdb,
  output logic              req,
  output rv32i_pkg::cdb_t   result,
  input  logic              grant
);

  localparam int N = 2 ** DEPTH;

  rv32i_pkg::issue_t ent [N];
  logic [N-1:0]      free;
  logic [DEPTH-1:0]  start;
  logic [DEPTH-1:0]  fill_idx;
  logic [DEPTH-1:0]  sel;
  rv32i_pkg::issue_t incoming;
  rv32i_pkg::issue_t cur;
  logic [31:0]       op_a;
  logic [31:0]       op_b;
  logic              is_reg;

  assign full = ~|free;

  always_comb begin
    fill_idx = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (free[i]) begin
        fill_idx = DEPTH'(i);
      end
    end
  end

  // immediate form never waits on rs2
  always_comb begin
    incoming = issue_pkt;
    if (issue_pkt.opcode == rv32i_pkg::imm_opcode) begin
      incoming.rs2.ready = 1'b1;
    end
    incoming.rs1 = rv32i_pkg::wake(incoming.rs1, cdb);
    incoming.rs2 = rv32i_pkg::wake(incoming.rs2, cdb);
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      free  <= '1;
      start <= '0;
    end else begin
      if (issue && !full) begin
        free[fill_idx] <= 1'b0;
      end
      if (req && grant) begin
        free[sel] <= 1'b1;
        start     <= sel + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < N; i++) begin
      if (issue && !full && fill_idx == DEPTH'(i)) begin
        ent[i] <= incoming;
      end else begin
        ent[i].rs1 <= rv32i_pkg::wake(ent[i].rs1, cdb);
        ent[i].rs2 <= rv32i_pkg::wake(ent[i].rs2, cdb);
      end
    end
  end

  always_comb begin
    logic [DEPTH-1:0] idx;
    req = 1'b0;
    sel = start;
    for (int i = 0; i < N; i++) begin
      idx = start + DEPTH'(i);
      if (!req && !free[idx] && ent[idx].rs1.ready && ent[idx].rs2.ready) begin
        req = 1'b1;
        sel = idx;
      end
    end
  end

  assign cur    = ent[sel];
  assign is_reg = (cur.opcode == rv32i_pkg::op_opcode);
  assign op_a   = cur.rs1.value;
  assign op_b   = is_reg ? cur.rs2.value : cur.imm;

  always_comb begin
    result.valid  = req;
    result.rob    = cur.rob;
    result.take   = 1'b0;
    result.target = '0;
    result.value  = '0;
    case (cur.funct3)
      // alt in an addi is just an imm bit
      rv32i_pkg::add_f3:  result.value = (is_reg && cur.alt) ? op_a - op_b : op_a + op_b;
      rv32i_pkg::slt_f3:  result.value = {31'd0, $signed(op_a) < $signed(op_b)};
      rv32i_pkg::sltu_f3: result.value = {31'd0, op_a < op_b};
      rv32i_pkg::xor_f3:  result.value = op_a ^ op_b;
      rv32i_pkg::or_f3:   result.value = op_a | op_b;
      rv32i_pkg::and_f3:  result.value = op_a & op_b;
      rv32i_pkg::sll_f3:  result.value = op_a << op_b[4:0];
      rv32i_pkg::sr_f3: begin
        if (cur.alt) begin
          result.value = $signed(op_a) >>> op_b[4:0];
        end else begin
          result.value = op_a >> op_b[4:0];
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/branch_rs.sv
`timescale 1ns/100ps
`default_nettype none

module branch_rs #(
  parameter int DEPTH = 2
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              flush,
  input  logic              issue,
  input  rv32i_pkg::issue_t issue_pkt,
  output logic              full,
  input  rv32i_pkg::cdb_t   cdb,
  output logic              req,
  output rv32i_pkg::cdb_t   result,
  input  logic              grant
);

  localparam int N = 2 ** DEPTH;

  rv32i_pkg::issue_t ent [N];
  logic [N-1:0]      free;
  logic [DEPTH-1:0]  start;
  logic [DEPTH-1:0]  fill_idx;
  logic [DEPTH-1:0]  sel;
  rv32i_pkg::issue_t incoming;
  rv32i_pkg::issue_t cur;
  logic              br_en;
  logic [31:0]       pc_link;
  logic [31:0]       pc_rel;

  assign full = ~|free;

  // lowest free slot
  always_comb begin
    fill_idx = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (free[i]) begin
        fill_idx = DEPTH'(i);
      end
    end
  end

  // jumps never wait on rs2 and jal never waits on rs1
  always_comb begin
    incoming = issue_pkt;
    case (issue_pkt.opcode)
      rv32i_pkg::jal_opcode: begin
        incoming.rs1.ready = 1'b1;
        incoming.rs2.ready = 1'b1;
      end
      rv32i_pkg::jalr_opcode: begin
        incoming.rs2.ready = 1'b1;
      end
      default: begin
      end
    endcase
    // a producer finishing on the issue edge is caught here
    incoming.rs1 = rv32i_pkg::wake(incoming.rs1, cdb);
    incoming.rs2 = rv32i_pkg::wake(incoming.rs2, cdb);
  end

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      free  <= '1;
      start <= '0;
    end else begin
      if (issue && !full) begin
        free[fill_idx] <= 1'b0;
      end
      if (req && grant) begin
        free[sel] <= 1'b1;
        start     <= sel + 1'b1;
      end
    end
  end

  // entry payload and cdb snoop
  always_ff @(posedge clk) begin
    for (int i = 0; i < N; i++) begin
      if (issue && !full && fill_idx == DEPTH'(i)) begin
        ent[i] <= incoming;
      end else begin
        ent[i].rs1 <= rv32i_pkg::wake(ent[i].rs1, cdb);
        ent[i].rs2 <= rv32i_pkg::wake(ent[i].rs2, cdb);
      end
    end
  end

  // oldest ready entry in round robin order from start
  always_comb begin
    logic [DEPTH-1:0] idx;
    req = 1'b0;
    sel = start;
    for (int i = 0; i < N; i++) begin
      idx = start + DEPTH'(i);
      if (!req && !free[idx] && ent[idx].rs1.ready && ent[idx].rs2.ready) begin
        req = 1'b1;
        sel = idx;
      end
    end
  end

  assign cur     = ent[sel];
  assign pc_link = cur.pc + 32'd4;
  assign pc_rel  = cur.pc + cur.imm;

  branch_cmp cmp_i (
    .funct3 (cur.funct3),
    .a      (cur.rs1.value),
    .b      (cur.rs2.value),
    .br_en  (br_en)
  );

  always_comb begin
    result.valid = req;
    result.rob   = cur.rob;
    case (cur.opcode)
      rv32i_pkg::jal_opcode: begin
        result.value  = pc_link;
        result.take   = 1'b1;
        result.target = pc_rel;
      end
      rv32i_pkg::jalr_opcode: begin
        result.value  = pc_link;
        result.take   = 1'b1;
        result.target = (cur.rs1.value + cur.imm) & ~32'd1;
      end
      default: begin
        // conditional branch writes no register
        result.value  = '0;
        result.take   = br_en;
        result.target = br_en ? pc_rel : pc_link;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/branch_cmp.sv
`timescale 1ns/100ps
`default_nettype none

module branch_cmp (
  input  logic [2:0]  funct3,
  input  logic [31:0] a,
  input  logic [31:0] b,
  output logic        br_en
);

  always_comb begin
    case (funct3)
      rv32i_pkg::beq_f3:  br_en = (a == b);
      rv32i_pkg::bne_f3:  br_en = (a != b);
      rv32i_pkg::blt_f3:  br_en = ($signed(a) < $signed(b));
      rv32i_pkg::bge_f3:  br_en = ($signed(a) >= $signed(b));
      rv32i_pkg::bltu_f3: br_en = (a < b);
      rv32i_pkg::bgeu_f3: br_en = (a >= b);
      // 010 and 011 are not branches
      default:            br_en = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

  // rob tag width and rob depth in bits
  localparam int rob_width = 3;

  // major opcodes
  localparam logic [6:0] jal_opcode  = 7'b1101111;
  localparam logic [6:0] jalr_opcode = 7'b1100111;
  localparam logic [6:0] br_opcode   = 7'b1100011;
  localparam logic [6:0] op_opcode   = 7'b0110011;
  localparam logic [6:0] imm_opcode  = 7'b0010011;

  // branch conditions
  localparam logic [2:0] beq_f3  = 3'b000;
  localparam logic [2:0] bne_f3  = 3'b001;
  localparam logic [2:0] blt_f3  = 3'b100;
  localparam logic [2:0] bge_f3  = 3'b101;
  localparam logic [2:0] bltu_f3 = 3'b110;
  localparam logic [2:0] bgeu_f3 = 3'b111;

  // alu ops with sub and sra flagged by funct7 bit 5
  localparam logic [2:0] add_f3  = 3'b000;
  localparam logic [2:0] sll_f3  = 3'b001;
  localparam logic [2:0] slt_f3  = 3'b010;
  localparam logic [2:0] sltu_f3 = 3'b011;
  localparam logic [2:0] xor_f3  = 3'b100;
  localparam logic [2:0] sr_f3   = 3'b101;
  localparam logic [2:0] or_f3   = 3'b110;
  localparam logic [2:0] and_f3  = 3'b111;

  typedef struct packed {
    logic                 ready;
    logic [31:0]          value;
    logic [rob_width-1:0] tag;
  } operand_t;

  typedef struct packed {
    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic                 alt;
    logic [31:0]          imm;
    logic [31:0]          pc;
    operand_t             rs1;
    operand_t             rs2;
    logic [rob_width-1:0] rob;
  } issue_t;

  typedef struct packed {
    logic                 valid;
    logic [rob_width-1:0] rob;
    logic [31:0]          value;
    logic                 take;
    logic [31:0]          target;
  } cdb_t;

  // picks up a waiting operand when its producer is on the bus
  function automatic operand_t wake(operand_t op, cdb_t beat);
    operand_t res;
    res = op;
    if (!op.ready && beat.valid && beat.rob == op.tag) begin
      res.ready = 1'b1;
      res.value = beat.value;
    end
    return res;
  endfunction

endpackage

`default_nettype wire
